//--- design/ex_config.svh
// Width macros and exception constants for the execute stage
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

// Data and address width
`define EX_XLEN 32

// Scoreboard tag width
`define EX_TRANS_ID_BITS 3

// Address-space id and CSR address widths
`define EX_ASID_WIDTH 4
`define EX_CSR_ADDR_BITS 12

// Compressed instructions: link step of 2 and halfword-aligned targets
`define EX_RVC 1

// Exception cause for a misaligned fetch target
`define EX_CAUSE_INSTR_MISALIGNED 0

`endif

//--- design/fu_pkg.sv
// Operator encoding, issued-instruction struct and data types of the execute stage
`include "ex_config.svh"

package fu_pkg;

    // --------------------
    // Data types
    // --------------------
    typedef logic [`EX_XLEN-1:0]          xlen_t;
    typedef logic [`EX_TRANS_ID_BITS-1:0] trans_id_t;

    // --------------------
    // Operators
    // --------------------
    typedef enum logic [4:0] {
        // ALU arithmetic, logic, shifts and set-less-than
        ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLTS, SLTU,
        // Conditional branches
        EQ, NE, LTS, LTU, GES, GEU,
        // Jumps
        JAL, JALR,
        // CSR access
        CSR_RW,
        // Multiplier
        MUL, MULH, MULHU,
        // Address translation fence
        SFENCE_VMA
    } fu_op_t;

    // Instruction as it leaves the issue stage
    typedef struct packed {
        fu_op_t    operator;
        xlen_t     operand_a;
        xlen_t     operand_b;
        xlen_t     imm;
        trans_id_t trans_id;
    } fu_data_t;

endpackage

//--- design/ctrl_flow_pkg.sv
// Branch prediction, branch resolution and exception structs

package ctrl_flow_pkg;

    // Prediction that travels with the instruction from fetch
    typedef struct packed {
        logic          cf;
        fu_pkg::xlen_t predict_address;
    } branchpredict_sbe_t;

    // Resolution sent back to the frontend
    typedef struct packed {
        logic          valid;
        fu_pkg::xlen_t pc;
        fu_pkg::xlen_t target_address;
        logic          is_mispredict;
        logic          is_taken;
    } bp_resolve_t;

    // Exception raised by a functional unit
    typedef struct packed {
        logic          valid;
        fu_pkg::xlen_t cause;
        fu_pkg::xlen_t tval;
    } exception_t;

endpackage

//--- design/ex_alu.sv
// Combinational ALU with branch comparison output
`timescale 1ns/100ps
`include "ex_config.svh"

module ex_alu (
    input  fu_pkg::fu_data_t fu_data_i,
    output fu_pkg::xlen_t    result_o,
    output logic             branch_res_o
);

    localparam int SHAMT_W = $clog2(`EX_XLEN);

    fu_pkg::xlen_t        op_a;
    fu_pkg::xlen_t        op_b;
    fu_pkg::xlen_t        sum;
    fu_pkg::xlen_t        diff;
    logic [SHAMT_W-1:0]   shamt;
    logic                 lt_signed;
    logic                 lt_unsigned;

    assign op_a  = fu_data_i.operand_a;
    assign op_b  = fu_data_i.operand_b;
    assign sum   = op_a + op_b;
    assign diff  = op_a - op_b;
    assign shamt = op_b[SHAMT_W-1:0];

    // Shared by set-less-than and the branch compares
    assign lt_signed   = $signed(op_a) < $signed(op_b);
    assign lt_unsigned = op_a < op_b;

    // --------------------
    // Result
    // --------------------
    always_comb begin
        case (fu_data_i.operator)
            fu_pkg::SUB:  result_o = diff;
            fu_pkg::AND:  result_o = op_a & op_b;
            fu_pkg::OR:   result_o = op_a | op_b;
            fu_pkg::XOR:  result_o = op_a ^ op_b;
            fu_pkg::SLL:  result_o = op_a << shamt;
            fu_pkg::SRL:  result_o = op_a >> shamt;
            fu_pkg::SRA:  result_o = $unsigned($signed(op_a) >>> shamt);
            fu_pkg::SLTS: result_o = {{(`EX_XLEN-1){1'b0}}, lt_signed};
            fu_pkg::SLTU: result_o = {{(`EX_XLEN-1){1'b0}}, lt_unsigned};
            default:      result_o = sum;
        endcase
    end

    // --------------------
    // Branch comparison
    // --------------------
    always_comb begin
        case (fu_data_i.operator)
            fu_pkg::EQ:  branch_res_o = (op_a == op_b);
            fu_pkg::NE:  branch_res_o = (op_a != op_b);
            fu_pkg::LTS: branch_res_o = lt_signed;
            fu_pkg::LTU: branch_res_o = lt_unsigned;
            fu_pkg::GES: branch_res_o = ~lt_signed;
            fu_pkg::GEU: branch_res_o = ~lt_unsigned;
            default:     branch_res_o = 1'b0;
        endcase
    end

endmodule

//--- design/ex_branch_unit.sv
// Branch unit: target and link address, resolution and misaligned-target exception
`timescale 1ns/100ps
`include "ex_config.svh"

module ex_branch_unit (
    input  fu_pkg::fu_data_t                  fu_data_i,
    input  fu_pkg::xlen_t                     pc_i,
    input  logic                              is_compressed_instr_i,
    input  logic                              fu_valid_i,
    input  logic                              branch_valid_i,
    input  logic                              branch_comp_res_i,
    input  ctrl_flow_pkg::branchpredict_sbe_t branch_predict_i,
    output fu_pkg::xlen_t                     branch_result_o,
    output ctrl_flow_pkg::bp_resolve_t        resolved_branch_o,
    output logic                              resolve_branch_o,
    output ctrl_flow_pkg::exception_t         branch_exception_o
);

    fu_pkg::xlen_t target;
    fu_pkg::xlen_t jalr_sum;
    fu_pkg::xlen_t link_addr;
    logic          is_jump;
    logic          taken;
    logic          misaligned;

    assign is_jump = (fu_data_i.operator == fu_pkg::JAL) ||
                     (fu_data_i.operator == fu_pkg::JALR);
    assign taken   = is_jump | branch_comp_res_i;

    // JALR is register relative, everything else is PC relative
    assign jalr_sum = fu_data_i.operand_a + fu_data_i.imm;
    assign target   = (fu_data_i.operator == fu_pkg::JALR) ?
                      {jalr_sum[`EX_XLEN-1:1], 1'b0} : pc_i + fu_data_i.imm;

    // Without RVC the step is always a full word
    assign link_addr = pc_i + ((`EX_RVC && is_compressed_instr_i) ? 'd2 : 'd4);
    assign branch_result_o = link_addr;

    assign misaligned = `EX_RVC ? target[0] : |target[1:0];

    // --------------------
    // Resolution
    // --------------------
    always_comb begin
        resolved_branch_o                = '0;
        resolved_branch_o.pc             = pc_i;
        resolved_branch_o.target_address = link_addr;
        resolve_branch_o                 = 1'b0;

        if (branch_valid_i) begin
            resolved_branch_o.valid          = 1'b1;
            resolved_branch_o.is_taken       = taken;
            resolved_branch_o.target_address = taken ? target : link_addr;
            resolved_branch_o.is_mispredict  = (taken != branch_predict_i.cf) ||
                (taken && (target != branch_predict_i.predict_address));
            resolve_branch_o                 = 1'b1;
        end else if (fu_valid_i && branch_predict_i.cf) begin
            // Predicted as control flow but is not a branch, fall through
            resolved_branch_o.valid         = 1'b1;
            resolved_branch_o.is_mispredict = 1'b1;
            resolve_branch_o                = 1'b1;
        end
    end

    // --------------------
    // Exception
    // --------------------
    always_comb begin
        branch_exception_o       = '0;
        branch_exception_o.cause = `EX_CAUSE_INSTR_MISALIGNED;
        branch_exception_o.tval  = target;
        branch_exception_o.valid = branch_valid_i && taken && misaligned;
    end

endmodule

//--- design/ex_csr_buffer.sv
// One-entry CSR address buffer held until commit
`timescale 1ns/100ps
`include "ex_config.svh"

module ex_csr_buffer (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         flush_i,
    input  fu_pkg::fu_data_t             fu_data_i,
    input  logic                         csr_valid_i,
    input  logic                         csr_commit_i,
    output logic                         csr_ready_o,
    output fu_pkg::xlen_t                csr_result_o,
    output logic [`EX_CSR_ADDR_BITS-1:0] csr_addr_o
);

    logic                         full_q;
    logic [`EX_CSR_ADDR_BITS-1:0] addr_q;

    // Write data goes to the register file side unchanged
    assign csr_result_o = fu_data_i.operand_a;
    assign csr_ready_o  = ~full_q;
    assign csr_addr_o   = addr_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            full_q <= 1'b0;
        end else if (flush_i) begin
            full_q <= 1'b0;
        end else if (csr_valid_i) begin
            full_q <= 1'b1;
        end else if (csr_commit_i) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (csr_valid_i) begin
            addr_q <= fu_data_i.operand_b[`EX_CSR_ADDR_BITS-1:0];
        end
    end

    // Issue must respect the ready level
    assert property (@(posedge clk_i) disable iff (!rst_ni) csr_valid_i |-> !full_q)
        else $error("CSR issued while buffer is full");

endmodule

//--- design/ex_multiplier.sv
// Single-cycle registered multiplier with flush
`timescale 1ns/100ps
`include "ex_config.svh"

module ex_multiplier (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              flush_i,
    input  logic              mult_valid_i,
    input  fu_pkg::fu_data_t  fu_data_i,
    output fu_pkg::xlen_t     result_o,
    output logic              valid_o,
    output fu_pkg::trans_id_t trans_id_o
);

    logic [2*`EX_XLEN-1:0] prod_s;
    logic [2*`EX_XLEN-1:0] prod_u;
    fu_pkg::xlen_t         result_d;
    fu_pkg::xlen_t         op_a;
    fu_pkg::xlen_t         op_b;

    assign op_a = fu_data_i.operand_a;
    assign op_b = fu_data_i.operand_b;

    // Signed product through sign extension, low half is shared
    assign prod_s = {{`EX_XLEN{op_a[`EX_XLEN-1]}}, op_a} *
                    {{`EX_XLEN{op_b[`EX_XLEN-1]}}, op_b};
    assign prod_u = {{`EX_XLEN{1'b0}}, op_a} * {{`EX_XLEN{1'b0}}, op_b};

    always_comb begin
        case (fu_data_i.operator)
            fu_pkg::MULH:  result_d = prod_s[2*`EX_XLEN-1:`EX_XLEN];
            fu_pkg::MULHU: result_d = prod_u[2*`EX_XLEN-1:`EX_XLEN];
            default:       result_d = prod_u[`EX_XLEN-1:0];
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= mult_valid_i & ~flush_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (mult_valid_i) begin
            result_o   <= result_d;
            trans_id_o <= fu_data_i.trans_id;
        end
    end

endmodule

//--- design/ex_sfence_capture.sv
// SFENCE.VMA detection and capture of the fence operands
`timescale 1ns/100ps
`include "ex_config.svh"

module ex_sfence_capture (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      flush_i,
    input  fu_pkg::fu_data_t          fu_data_i,
    input  logic                      csr_valid_i,
    input  fu_pkg::xlen_t             rs1_forwarding_i,
    input  fu_pkg::xlen_t             rs2_forwarding_i,
    output fu_pkg::xlen_t             vaddr_to_be_flushed_o,
    output logic [`EX_ASID_WIDTH-1:0] asid_to_be_flushed_o
);

    logic is_sfence;
    logic sfence_q;

    // SFENCE rides on the CSR strobe
    assign is_sfence = csr_valid_i && (fu_data_i.operator == fu_pkg::SFENCE_VMA);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sfence_q <= 1'b0;
        end else begin
            sfence_q <= is_sfence & ~flush_i;
        end
    end

    // Hold the operands during the fence and the cycle after it
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            vaddr_to_be_flushed_o <= '0;
            asid_to_be_flushed_o  <= '0;
        end else if (!sfence_q && !is_sfence) begin
            vaddr_to_be_flushed_o <= rs1_forwarding_i;
            asid_to_be_flushed_o  <= rs2_forwarding_i[`EX_ASID_WIDTH-1:0];
        end
    end

endmodule

//--- design/ex_stage.sv
// Execute stage top with fixed-latency units, operand silencing and write-back result path
`timescale 1ns/100ps
`include "ex_config.svh"

module ex_stage (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic                              flush_i,
    input  fu_pkg::fu_data_t                  fu_data_i,
    input  fu_pkg::xlen_t                     pc_i,
    input  logic                              is_compressed_instr_i,
    // Forwarded register operands
    input  fu_pkg::xlen_t                     rs1_forwarding_i,
    input  fu_pkg::xlen_t                     rs2_forwarding_i,
    // Unit strobes
    input  logic                              alu_valid_i,
    input  logic                              branch_valid_i,
    input  logic                              csr_valid_i,
    input  logic                              mult_valid_i,
    input  logic                              csr_commit_i,
    input  ctrl_flow_pkg::branchpredict_sbe_t branch_predict_i,
    // Shared write-back port
    output fu_pkg::xlen_t                     flu_result_o,
    output fu_pkg::trans_id_t                 flu_trans_id_o,
    output ctrl_flow_pkg::exception_t         flu_exception_o,
    output logic                              flu_ready_o,
    output logic                              flu_valid_o,
    // Branch resolution
    output ctrl_flow_pkg::bp_resolve_t        resolved_branch_o,
    output logic                              resolve_branch_o,
    output logic [`EX_CSR_ADDR_BITS-1:0]      csr_addr_o,
    // Fence operands
    output fu_pkg::xlen_t                     vaddr_to_be_flushed_o,
    output logic [`EX_ASID_WIDTH-1:0]         asid_to_be_flushed_o
);

    fu_pkg::fu_data_t  alu_data;
    fu_pkg::fu_data_t  mult_data;
    fu_pkg::xlen_t     alu_result;
    fu_pkg::xlen_t     branch_result;
    fu_pkg::xlen_t     csr_result;
    fu_pkg::xlen_t     mult_result;
    fu_pkg::trans_id_t mult_trans_id;
    logic              alu_branch_res;
    logic              csr_ready;
    logic              mult_valid;

    // --------------------
    // Operand silencing
    // --------------------
    assign alu_data  = (alu_valid_i | branch_valid_i) ? fu_data_i : '0;
    assign mult_data = mult_valid_i ? fu_data_i : '0;

    ex_alu u_alu (
        .fu_data_i    (alu_data),
        .result_o     (alu_result),
        .branch_res_o (alu_branch_res)
    );

    // Non-branch strobes feed the false-prediction check
    ex_branch_unit u_branch_unit (
        .fu_data_i             (fu_data_i),
        .pc_i                  (pc_i),
        .is_compressed_instr_i (is_compressed_instr_i),
        .fu_valid_i            (alu_valid_i | csr_valid_i | mult_valid_i),
        .branch_valid_i        (branch_valid_i),
        .branch_comp_res_i     (alu_branch_res),
        .branch_predict_i      (branch_predict_i),
        .branch_result_o       (branch_result),
        .resolved_branch_o     (resolved_branch_o),
        .resolve_branch_o      (resolve_branch_o),
        .branch_exception_o    (flu_exception_o)
    );

    ex_csr_buffer u_csr_buffer (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .fu_data_i    (fu_data_i),
        .csr_valid_i  (csr_valid_i),
        .csr_commit_i (csr_commit_i),
        .csr_ready_o  (csr_ready),
        .csr_result_o (csr_result),
        .csr_addr_o   (csr_addr_o)
    );

    ex_multiplier u_multiplier (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .mult_valid_i (mult_valid_i),
        .fu_data_i    (mult_data),
        .result_o     (mult_result),
        .valid_o      (mult_valid),
        .trans_id_o   (mult_trans_id)
    );

    ex_sfence_capture u_sfence_capture (
        .clk_i                 (clk_i),
        .rst_ni                (rst_ni),
        .flush_i               (flush_i),
        .fu_data_i             (fu_data_i),
        .csr_valid_i           (csr_valid_i),
        .rs1_forwarding_i      (rs1_forwarding_i),
        .rs2_forwarding_i      (rs2_forwarding_i),
        .vaddr_to_be_flushed_o (vaddr_to_be_flushed_o),
        .asid_to_be_flushed_o  (asid_to_be_flushed_o)
    );

    // --------------------
    // Write-back
    // --------------------
    always_comb begin
        // Link address unless another unit owns the port
        flu_result_o   = branch_result;
        flu_trans_id_o = fu_data_i.trans_id;
        if (alu_valid_i) begin
            flu_result_o = alu_result;
        end else if (csr_valid_i) begin
            flu_result_o = csr_result;
        end else if (mult_valid) begin
            flu_result_o   = mult_result;
            flu_trans_id_o = mult_trans_id;
        end
    end

    assign flu_valid_o = alu_valid_i | branch_valid_i | csr_valid_i | mult_valid;
    assign flu_ready_o = csr_ready;

    // Strobes are one-hot
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({alu_valid_i, branch_valid_i, csr_valid_i, mult_valid_i}))
        else $error("More than one unit strobe high");

    // Multiplier owns the write-back port in the cycle after its issue
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        mult_valid_i |=> !(alu_valid_i || branch_valid_i || csr_valid_i))
        else $error("Write-back collision with multiplier result");

endmodule

//--- dv/tb_ex_stage.sv
// Testbench for ex_stage with random stimulus, reference model, compare tasks and timeout
`timescale 1ns/100ps
`include "ex_config.svh"

module tb_ex_stage;

    localparam int N_ALU = 40;
    localparam int N_BR  = 40;
    localparam int N_NB  = 12;
    localparam int N_CSR = 6;
    localparam int N_MUL = 30;
    localparam int N_SF  = 4;
    localparam int TOTAL_OPS = N_ALU + N_BR + N_NB + N_CSR + N_MUL + N_SF;
    localparam int CYCLE_LIMIT = 4 * TOTAL_OPS + 100;

    logic clk_i, rst_ni, flush_i, is_compressed_instr_i, csr_commit_i;
    logic alu_valid_i, branch_valid_i, csr_valid_i, mult_valid_i;
    fu_pkg::fu_data_t fu_data_i;
    fu_pkg::xlen_t pc_i, rs1_forwarding_i, rs2_forwarding_i;
    ctrl_flow_pkg::branchpredict_sbe_t branch_predict_i;
    fu_pkg::xlen_t flu_result_o, vaddr_to_be_flushed_o;
    fu_pkg::trans_id_t flu_trans_id_o;
    ctrl_flow_pkg::exception_t flu_exception_o;
    ctrl_flow_pkg::bp_resolve_t resolved_branch_o;
    logic flu_ready_o, flu_valid_o, resolve_branch_o;
    logic [`EX_CSR_ADDR_BITS-1:0] csr_addr_o;
    logic [`EX_ASID_WIDTH-1:0] asid_to_be_flushed_o;

    int errors = 0;
    int test_start_errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int cycles = 0;

    ex_stage uut (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // Run limit
    always @(posedge clk_i) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: run went past %0d cycles", CYCLE_LIMIT);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // --------------------
    // Compare tasks
    // --------------------
    task automatic check_xlen(string name, fu_pkg::xlen_t exp, fu_pkg::xlen_t act);
        if (exp !== act) begin
            errors++;
            $display("[ERROR] %s expected %h got %h", name, exp, act);
        end
    endtask

    task automatic check_trans_id(string name, fu_pkg::trans_id_t exp,
                                  fu_pkg::trans_id_t act);
        if (exp !== act) begin
            errors++;
            $display("[ERROR] %s expected %h got %h", name, exp, act);
        end
    endtask

    task automatic check_resolve(string name, ctrl_flow_pkg::bp_resolve_t exp,
                                 ctrl_flow_pkg::bp_resolve_t act);
        // Fields only matter while valid
        if (exp.valid !== act.valid || (exp.valid && exp !== act)) begin
            errors++;
            $display("[ERROR] %s expected %h got %h", name, exp, act);
        end
    endtask

    task automatic check_exception(string name, ctrl_flow_pkg::exception_t exp,
                                   ctrl_flow_pkg::exception_t act);
        if (exp.valid !== act.valid || (exp.valid && exp !== act)) begin
            errors++;
            $display("[ERROR] %s expected %h got %h", name, exp, act);
        end
    endtask

    // --------------------
    // Reference model
    // --------------------
    function automatic fu_pkg::xlen_t alu_model(fu_pkg::fu_op_t op, fu_pkg::xlen_t a,
                                                fu_pkg::xlen_t b);
        case (op)
            fu_pkg::ADD:  return a + b;
            fu_pkg::SUB:  return a - b;
            fu_pkg::AND:  return a & b;
            fu_pkg::OR:   return a | b;
            fu_pkg::XOR:  return a ^ b;
            fu_pkg::SLL:  return a << b[4:0];
            fu_pkg::SRL:  return a >> b[4:0];
            fu_pkg::SRA:  return $unsigned($signed(a) >>> b[4:0]);
            fu_pkg::SLTS: return ($signed(a) < $signed(b)) ? 1 : 0;
            default:      return (a < b) ? 1 : 0;
        endcase
    endfunction

    function automatic logic taken_model(fu_pkg::fu_op_t op, fu_pkg::xlen_t a,
                                         fu_pkg::xlen_t b);
        case (op)
            fu_pkg::EQ:  return a == b;
            fu_pkg::NE:  return a != b;
            fu_pkg::LTS: return $signed(a) < $signed(b);
            fu_pkg::LTU: return a < b;
            fu_pkg::GES: return $signed(a) >= $signed(b);
            fu_pkg::GEU: return a >= b;
            default:     return 1'b1;
        endcase
    endfunction

    function automatic fu_pkg::xlen_t mul_model(fu_pkg::fu_op_t op, fu_pkg::xlen_t a,
                                                fu_pkg::xlen_t b);
        logic [63:0] ps;
        logic [63:0] pu;
        ps = $unsigned(longint'($signed(a)) * longint'($signed(b)));
        pu = {32'd0, a} * {32'd0, b};
        case (op)
            fu_pkg::MULH:  return ps[63:32];
            fu_pkg::MULHU: return pu[63:32];
            default:       return pu[31:0];
        endcase
    endfunction

    // --------------------
    // Stimulus helpers
    // --------------------
    task automatic next_cycle();
        @(posedge clk_i);
        #2;
        {alu_valid_i, branch_valid_i, csr_valid_i, mult_valid_i} = '0;
        csr_commit_i     = 1'b0;
        flush_i          = 1'b0;
        branch_predict_i = '0;
        rs1_forwarding_i = $urandom;
        rs2_forwarding_i = $urandom;
    endtask

    task automatic random_data(fu_pkg::fu_op_t op);
        fu_data_i.operator  = op;
        fu_data_i.operand_a = $urandom;
        fu_data_i.operand_b = ($urandom_range(0, 3) == 0) ? fu_data_i.operand_a : $urandom;
        fu_data_i.imm       = $urandom;
        fu_data_i.trans_id  = $urandom;
        pc_i                = $urandom & ~32'h1;
        is_compressed_instr_i = $urandom;
    endtask

    task automatic finish_test(string name);
        if (errors == test_start_errors) begin
            tests_passed++;
            $display("Test %s: ok", name);
        end else begin
            tests_failed++;
            $display("Test %s: %0d errors", name, errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    // Checks one cycle of the SFENCE hold against the model, then advances the model
    fu_pkg::xlen_t sf_vaddr;
    logic [`EX_ASID_WIDTH-1:0] sf_asid;
    logic sf_flag;

    task automatic sfence_cycle(logic issue, logic commit, logic check);
        next_cycle();
        fu_data_i.operator = issue ? fu_pkg::SFENCE_VMA : fu_pkg::ADD;
        csr_valid_i  = issue;
        csr_commit_i = commit;
        #16;
        if (check) begin
            check_xlen("vaddr_to_be_flushed_o", sf_vaddr, vaddr_to_be_flushed_o);
            check_xlen("asid_to_be_flushed_o", fu_pkg::xlen_t'(sf_asid),
                       fu_pkg::xlen_t'(asid_to_be_flushed_o));
        end
        if (!sf_flag && !issue) begin
            sf_vaddr = rs1_forwarding_i;
            sf_asid  = rs2_forwarding_i[`EX_ASID_WIDTH-1:0];
        end
        sf_flag = issue;
    endtask

    // --------------------
    // Tests
    // --------------------
    initial begin
        ctrl_flow_pkg::bp_resolve_t exp_res;
        ctrl_flow_pkg::exception_t  exp_exc;
        fu_pkg::xlen_t target, link, pend_result;
        fu_pkg::trans_id_t pend_id;
        logic taken, pend;
        int waits;

        void'($urandom(19516));
        rst_ni = 1'b0;
        fu_data_i = '0;
        pc_i = '0;
        is_compressed_instr_i = 1'b0;
        rs1_forwarding_i = '0;
        rs2_forwarding_i = '0;
        {alu_valid_i, branch_valid_i, csr_valid_i, mult_valid_i} = '0;
        csr_commit_i = 1'b0;
        flush_i = 1'b0;
        branch_predict_i = '0;
        repeat (3) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;

        for (int i = 0; i < N_ALU; i++) begin
            next_cycle();
            random_data(fu_pkg::fu_op_t'($urandom_range(0, 9)));
            alu_valid_i = 1'b1;
            exp_res = '0;
            #16;
            check_xlen("flu_result_o", alu_model(fu_data_i.operator, fu_data_i.operand_a,
                       fu_data_i.operand_b), flu_result_o);
            check_trans_id("flu_trans_id_o", fu_data_i.trans_id, flu_trans_id_o);
            check_xlen("flu_valid_o", 1, fu_pkg::xlen_t'(flu_valid_o));
            check_xlen("resolve_branch_o", 0, fu_pkg::xlen_t'(resolve_branch_o));
            check_resolve("resolved_branch_o", exp_res, resolved_branch_o);
        end
        finish_test("alu");

        for (int i = 0; i < N_BR; i++) begin
            next_cycle();
            random_data(fu_pkg::fu_op_t'($urandom_range(10, 17)));
            if ($urandom_range(0, 3) != 0) fu_data_i.imm[0] = 1'b0;
            branch_valid_i = 1'b1;
            taken = taken_model(fu_data_i.operator, fu_data_i.operand_a, fu_data_i.operand_b);
            target = (fu_data_i.operator == fu_pkg::JALR) ?
                     (fu_data_i.operand_a + fu_data_i.imm) & ~32'h1 : pc_i + fu_data_i.imm;
            link = pc_i + (is_compressed_instr_i ? 2 : 4);
            branch_predict_i.cf = $urandom;
            branch_predict_i.predict_address = $urandom_range(0, 1) ? target : $urandom;
            exp_res = '{valid: 1'b1, pc: pc_i, target_address: taken ? target : link,
                        is_mispredict: (taken != branch_predict_i.cf) ||
                        (taken && target != branch_predict_i.predict_address),
                        is_taken: taken};
            exp_exc = '{valid: taken && target[0], cause: 0, tval: target};
            #16;
            check_resolve("resolved_branch_o", exp_res, resolved_branch_o);
            check_exception("flu_exception_o", exp_exc, flu_exception_o);
            check_xlen("flu_result_o", link, flu_result_o);
            check_trans_id("flu_trans_id_o", fu_data_i.trans_id, flu_trans_id_o);
            check_xlen("resolve_branch_o", 1, fu_pkg::xlen_t'(resolve_branch_o));
        end
        finish_test("branch");

        for (int i = 0; i < N_NB; i++) begin
            next_cycle();
            random_data(fu_pkg::fu_op_t'($urandom_range(0, 9)));
            alu_valid_i = 1'b1;
            branch_predict_i = '{cf: 1'b1, predict_address: $urandom};
            exp_res = '{valid: 1'b1, pc: pc_i,
                        target_address: pc_i + (is_compressed_instr_i ? 2 : 4),
                        is_mispredict: 1'b1, is_taken: 1'b0};
            #16;
            check_resolve("resolved_branch_o", exp_res, resolved_branch_o);
            check_xlen("resolve_branch_o", 1, fu_pkg::xlen_t'(resolve_branch_o));
        end
        finish_test("false_prediction");

        for (int i = 0; i < N_CSR; i++) begin
            next_cycle();
            random_data(fu_pkg::CSR_RW);
            csr_valid_i = 1'b1;
            #16;
            check_xlen("flu_result_o", fu_data_i.operand_a, flu_result_o);
            check_xlen("flu_valid_o", 1, fu_pkg::xlen_t'(flu_valid_o));
            waits = $urandom_range(1, 3);
            for (int w = 0; w < waits; w++) begin
                next_cycle();
                #16;
                check_xlen("flu_ready_o", 0, fu_pkg::xlen_t'(flu_ready_o));
                check_xlen("csr_addr_o", fu_data_i.operand_b[11:0], csr_addr_o);
            end
            next_cycle();
            if (i % 2 == 0) csr_commit_i = 1'b1;
            else flush_i = 1'b1;
            next_cycle();
            #16;
            check_xlen("flu_ready_o", 1, fu_pkg::xlen_t'(flu_ready_o));
        end
        finish_test("csr");

        pend = 1'b0;
        for (int i = 0; i <= N_MUL; i++) begin
            next_cycle();
            if (i < N_MUL) begin
                random_data(fu_pkg::fu_op_t'($urandom_range(19, 21)));
                mult_valid_i = 1'b1;
                flush_i = ($urandom_range(0, 7) == 0);
            end
            #16;
            check_xlen("flu_valid_o", fu_pkg::xlen_t'(pend), fu_pkg::xlen_t'(flu_valid_o));
            if (pend) begin
                check_xlen("flu_result_o", pend_result, flu_result_o);
                check_trans_id("flu_trans_id_o", pend_id, flu_trans_id_o);
            end
            pend = mult_valid_i && !flush_i;
            pend_result = mul_model(fu_data_i.operator, fu_data_i.operand_a,
                                    fu_data_i.operand_b);
            pend_id = fu_data_i.trans_id;
        end
        finish_test("multiplier");

        sf_flag = 1'b0;
        sfence_cycle(1'b0, 1'b0, 1'b0);
        for (int i = 0; i < N_SF; i++) begin
            sfence_cycle(1'b1, 1'b0, 1'b1);
            sfence_cycle(1'b0, 1'b1, 1'b1);
            sfence_cycle(1'b0, 1'b0, 1'b1);
            sfence_cycle(1'b0, 1'b0, 1'b1);
        end
        finish_test("sfence");

        $display("Tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+design
design/fu_pkg.sv
design/ctrl_flow_pkg.sv
design/ex_alu.sv
design/ex_branch_unit.sv
design/ex_csr_buffer.sv
design/ex_multiplier.sv
design/ex_sfence_capture.sv
design/ex_stage.sv
dv/tb_ex_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the execute-stage testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

out=$(verilator --binary --assert -Wno-fatal --top-module tb_ex_stage \
        -f sources.f -o sim_ex_stage && ./obj_dir/sim_ex_stage 2>&1)
status=$?
echo "$out"

[ $status -eq 0 ] && echo "$out" | grep -qx "=== PASS ===" && exit 0 || exit 1
